// File: src.f
logic/bp_types_pkg.sv
logic/bp_counter_pkg.sv
logic/choice_pht.sv
logic/direction_cache.sv
logic/yags_predictor.sv
logic/branch_controller.sv
verif/bp_clk_gen.sv
verif/bp_sva.sv
verif/tb_branch_controller.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_branch_controller
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "Result: run ended early"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_branch_controller.sv
`timescale 1ns/1ps

module tb_branch_controller;
    import bp_types_pkg::*;

    localparam int PHT_BITS      = 6;
    localparam int CIDX_BITS     = 4;
    localparam int TAG_BITS      = 6;
    localparam int MAX_ROWS      = 128;
    localparam int RESET_TIMEOUT = 20;  // Cycles
    localparam addr_t PC_A = 32'h0040_0010;
    localparam addr_t PC_B = 32'h0040_0520;
    localparam addr_t PC_D = 32'h0040_0030;  // History filler, never lands on B's slot
    localparam addr_t PC_E = 32'h0040_0044;

    typedef struct {
        int       test;
        logic     dec_valid;
        logic     dec_is_jump;
        addr_t    dec_pc;
        addr_t    dec_target;
        logic     ex_valid;
        addr_t    ex_pc;
        outcome_e ex_outcome;
        outcome_e exp_pred;
        addr_t    exp_target;
    } row_t;

    logic     clk;
    logic     rst_n;
    logic     dec_valid;
    logic     dec_is_jump;
    addr_t    dec_pc;
    addr_t    dec_target;
    logic     ex_valid;
    addr_t    ex_pc;
    outcome_e ex_outcome;
    outcome_e prediction;
    addr_t    recovery_target;

    row_t rows [MAX_ROWS];
    int   row_count   = 0;
    int   error_count = 0;

    // Reference model, counters as integers 0 to 3
    int m_choice [2**PHT_BITS];
    bit m_valid  [2**CIDX_BITS];
    int m_tag    [2**CIDX_BITS];
    int m_ctr    [2**CIDX_BITS];
    int m_ghr;

    bp_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    branch_controller #(
        .PHT_INDEX_BITS  (PHT_BITS),
        .CACHE_INDEX_BITS(CIDX_BITS),
        .TAG_BITS        (TAG_BITS)
    ) dut_i (
        .clk(clk), .rst_n(rst_n), .i_dec_valid(dec_valid), .i_dec_is_jump(dec_is_jump),
        .i_dec_pc(dec_pc), .i_dec_target(dec_target), .i_ex_valid(ex_valid), .i_ex_pc(ex_pc),
        .i_ex_outcome(ex_outcome), .o_prediction(prediction), .o_recovery_target(recovery_target)
    );

    function automatic int step_toward(input int c, input bit taken);
        if (taken) begin
            return (c < 3) ? c + 1 : 3;
        end
        return (c > 0) ? c - 1 : 0;
    endfunction

    function automatic int pht_slot(input addr_t pc);
        return int'(pc[PC_ALIGN_BITS +: PHT_BITS]);
    endfunction

    function automatic int tag_of(input addr_t pc);
        return int'(pc[PC_ALIGN_BITS +: TAG_BITS]);
    endfunction

    function automatic int cache_slot(input addr_t pc);
        return int'(pc[PC_ALIGN_BITS + TAG_BITS +: CIDX_BITS]) ^ m_ghr;
    endfunction

    function automatic void model_lookup(input addr_t pc, output bit hit, output bit taken);
        int slot;
        slot  = cache_slot(pc);
        hit   = m_valid[slot] && (m_tag[slot] == tag_of(pc));
        taken = hit ? (m_ctr[slot] >= 2) : (m_choice[pht_slot(pc)] >= 2);
    endfunction

    // Expected values come from the state before this row's feedback
    task automatic add_row(input int test, input logic dv, input logic jmp, input addr_t pc,
                           input addr_t tgt, input logic ev, input addr_t epc,
                           input outcome_e eout);
        row_t r;
        bit   hit;
        bit   taken;
        bit   out_t;
        bit   choice_ok;
        model_lookup(pc, hit, taken);
        r = '{test, dv, jmp, pc, tgt, ev, epc, eout, NOT_TAKEN, tgt};
        if (dv && !jmp && taken) begin
            r.exp_pred   = TAKEN;
            r.exp_target = pc + 32'd8;
        end
        if (ev) begin
            out_t     = (eout == TAKEN);
            model_lookup(epc, hit, taken);
            choice_ok = (m_choice[pht_slot(epc)] >= 2) == out_t;
            if (!(hit && taken == out_t && !choice_ok)) begin
                m_choice[pht_slot(epc)] = step_toward(m_choice[pht_slot(epc)], out_t);
            end
            if (hit) begin
                m_ctr[cache_slot(epc)] = step_toward(m_ctr[cache_slot(epc)], out_t);
            end else if (!choice_ok) begin
                m_valid[cache_slot(epc)] = 1'b1;
                m_tag[cache_slot(epc)]   = tag_of(epc);
                m_ctr[cache_slot(epc)]   = out_t ? 2 : 1;
            end
            m_ghr = ((m_ghr << 1) | int'(out_t)) & (2**CIDX_BITS - 1);
        end
        rows[row_count] = r;
        row_count++;
    endtask

    task automatic build_table();
        addr_t pc;
        addr_t epc;
        foreach (m_choice[i]) m_choice[i] = 1;
        foreach (m_valid[i]) begin
            m_valid[i] = 1'b0;
            m_tag[i]   = 0;
            m_ctr[i]   = 1;
        end
        m_ghr = 0;
        for (int i = 0; i < 4; i++) begin
            pc = 32'h0040_0000 + addr_t'(i * 'h104);
            add_row(1, 1'b1, 1'b0, pc, pc + 32'h40, 1'b0, '0, NOT_TAKEN);
        end
        for (int i = 0; i < 3; i++) add_row(2, 1'b1, 1'b0, PC_A, 32'h0040_1000, 1'b1, PC_A, TAKEN);
        add_row(2, 1'b1, 1'b0, PC_A, 32'h0040_1000, 1'b0, '0, NOT_TAKEN);
        for (int i = 0; i < 4; i++) add_row(3, 1'b0, 1'b0, '0, '0, 1'b1, PC_B, TAKEN);
        add_row(3, 1'b0, 1'b0, '0, '0, 1'b1, PC_B, NOT_TAKEN);  // Choice wrong, allocate
        for (int i = 0; i < 4; i++) add_row(3, 1'b0, 1'b0, '0, '0, 1'b1, PC_D, TAKEN);
        add_row(3, 1'b1, 1'b0, PC_B, 32'h0040_2000, 1'b0, '0, NOT_TAKEN);
        add_row(4, 1'b0, 1'b0, PC_A, 32'h0040_3000, 1'b0, '0, NOT_TAKEN);
        add_row(4, 1'b1, 1'b1, PC_A, 32'h0040_3000, 1'b0, '0, NOT_TAKEN);
        add_row(4, 1'b0, 1'b1, PC_A, 32'h0040_3000, 1'b1, PC_A, NOT_TAKEN);
        add_row(4, 1'b1, 1'b0, PC_A, 32'h0040_3000, 1'b0, '0, NOT_TAKEN);
        add_row(5, 1'b1, 1'b0, PC_E, 32'h0040_4000, 1'b1, PC_E, TAKEN);
        add_row(5, 1'b1, 1'b0, PC_E, 32'h0040_4000, 1'b0, '0, NOT_TAKEN);
        for (int i = 0; i < 60; i++) begin
            pc  = 32'h0040_0000 | (addr_t'($urandom_range(0, 7)) << 2)
                | (addr_t'($urandom_range(0, 3)) << 8);
            epc = 32'h0040_0000 | (addr_t'($urandom_range(0, 7)) << 2)
                | (addr_t'($urandom_range(0, 3)) << 8);
            add_row(6, $urandom_range(0, 9) < 8, $urandom_range(0, 9) == 0, pc,
                    {$urandom()} & 32'hffff_fffc, $urandom_range(0, 9) < 7, epc,
                    outcome_e'($urandom_range(0, 1)));
        end
    endtask

    task automatic wait_reset_release(output bit released);
        int cycles;
        released = 1'b0;
        cycles   = 0;
        while (!released && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            released = (rst_n === 1'b1);
        end
    endtask

    task automatic apply_rows();
        int test_rows;
        int test_errors;
        test_rows   = 0;
        test_errors = 0;
        for (int r = 0; r < row_count; r++) begin
            @(negedge clk);
            {dec_valid, dec_is_jump, dec_pc, dec_target} =
                {rows[r].dec_valid, rows[r].dec_is_jump, rows[r].dec_pc, rows[r].dec_target};
            ex_valid   = rows[r].ex_valid;
            ex_pc      = rows[r].ex_pc;
            ex_outcome = rows[r].ex_outcome;
            #3;  // Just ahead of the rising edge
            test_rows++;
            assert (prediction === rows[r].exp_pred) else begin
                $display("Error at %0t ns: row %0d prediction %0d, expected %0d",
                         $time, r, prediction, rows[r].exp_pred);
                test_errors++;
            end
            assert (recovery_target === rows[r].exp_target) else begin
                $display("Error at %0t ns: row %0d recovery target %h, expected %h",
                         $time, r, recovery_target, rows[r].exp_target);
                test_errors++;
            end
            if (r == row_count - 1 || rows[r + 1].test != rows[r].test) begin
                $display("Test %0d: %0d rows, %0d mismatches", rows[r].test, test_rows,
                         test_errors);
                error_count += test_errors;
                test_rows   = 0;
                test_errors = 0;
            end
        end
        @(negedge clk);
        dec_valid = 1'b0;
        ex_valid  = 1'b0;
    endtask

    initial begin
        bit released;
        int sva_failures;
        dec_valid   = 1'b1;  // Conditional request already waiting as reset lifts
        dec_is_jump = 1'b0;
        dec_pc      = PC_A;
        dec_target  = '0;
        ex_valid    = 1'b0;
        ex_pc       = '0;
        ex_outcome  = NOT_TAKEN;
        void'($urandom(32'h92dd_18b3));
        build_table();
        wait_reset_release(released);
        if (released) begin
            apply_rows();
        end else begin
            $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
            error_count++;
        end
        repeat (2) @(negedge clk);
        sva_failures = dut_i.sva_i.fail_count;
        $display("Summary: %0d rows, %0d mismatches, %0d assertion failures",
                 row_count, error_count, sva_failures);
        if (error_count == 0 && sva_failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/bp_sva.sv
`timescale 1ns/1ps

module bp_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   i_dec_valid,
    input logic                   i_dec_is_jump,
    input bp_types_pkg::addr_t    i_dec_pc,
    input bp_types_pkg::outcome_e o_prediction,
    input bp_types_pkg::addr_t    o_recovery_target
);
    import bp_types_pkg::*;

    int fail_count = 0;  // Picked up by the testbench summary

    a_pred_known: assert property (@(posedge clk) disable iff (!rst_n)
        (i_dec_valid && !i_dec_is_jump) |-> !$isunknown(o_prediction))
        else begin
            fail_count++;
            $error("prediction is unknown on a valid conditional request");
        end

    // Taken guess means recovery falls through past the delay slot
    a_taken_target: assert property (@(posedge clk) disable iff (!rst_n)
        (o_prediction == TAKEN) |-> (o_recovery_target == i_dec_pc + DELAY_SLOT_OFFSET))
        else begin
            fail_count++;
            $error("recovery target is not the PC plus the delay-slot offset");
        end

    a_reset_not_taken: assert property (@(posedge clk)
        $rose(rst_n) |-> (o_prediction == NOT_TAKEN))
        else begin
            fail_count++;
            $error("prediction is not NOT_TAKEN right after reset");
        end

endmodule

bind branch_controller bp_sva sva_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_dec_valid      (i_dec_valid),
    .i_dec_is_jump    (i_dec_is_jump),
    .i_dec_pc         (i_dec_pc),
    .o_prediction     (o_prediction),
    .o_recovery_target(o_recovery_target)
);

// File: verif/bp_clk_gen.sv
`timescale 1ns/1ps

module bp_clk_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // Released away from the rising edge
    end

endmodule

// File: logic/branch_controller.sv
`timescale 1ns/1ps

module branch_controller #(
    parameter int PHT_INDEX_BITS   = 6,
    parameter int CACHE_INDEX_BITS = 4,
    parameter int TAG_BITS         = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_dec_valid,
    input  logic                   i_dec_is_jump,
    input  bp_types_pkg::addr_t    i_dec_pc,
    input  bp_types_pkg::addr_t    i_dec_target,
    input  logic                   i_ex_valid,
    input  bp_types_pkg::addr_t    i_ex_pc,
    input  bp_types_pkg::outcome_e i_ex_outcome,
    output bp_types_pkg::outcome_e o_prediction,
    output bp_types_pkg::addr_t    o_recovery_target
);
    import bp_types_pkg::*;

    logic req_valid;

    // Jumps are unconditional, no prediction wanted
    assign req_valid = i_dec_valid && !i_dec_is_jump;

    yags_predictor #(
        .PHT_INDEX_BITS  (PHT_INDEX_BITS),
        .CACHE_INDEX_BITS(CACHE_INDEX_BITS),
        .TAG_BITS        (TAG_BITS)
    ) u_yags_predictor (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req_valid     (req_valid),
        .i_req_pc        (i_dec_pc),
        .o_req_prediction(o_prediction),
        .i_fb_valid      (i_ex_valid),
        .i_fb_pc         (i_ex_pc),
        .i_fb_outcome    (i_ex_outcome)
    );

    // Where fetch goes if the guess turns out wrong
    assign o_recovery_target = (o_prediction == TAKEN) ? i_dec_pc + DELAY_SLOT_OFFSET
                                                       : i_dec_target;

endmodule

// File: logic/yags_predictor.sv
`timescale 1ns/1ps

module yags_predictor #(
    parameter int PHT_INDEX_BITS   = 6,
    parameter int CACHE_INDEX_BITS = 4,
    parameter int TAG_BITS         = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_req_valid,
    input  bp_types_pkg::addr_t    i_req_pc,
    output bp_types_pkg::outcome_e o_req_prediction,
    input  logic                   i_fb_valid,
    input  bp_types_pkg::addr_t    i_fb_pc,
    input  bp_types_pkg::outcome_e i_fb_outcome
);
    import bp_types_pkg::*;
    import bp_counter_pkg::*;

    localparam int CIDX_LSB = PC_ALIGN_BITS + TAG_BITS;  // Cache index sits above the tag

    logic [CACHE_INDEX_BITS-1:0] ghr;  // Only the bits used for hashing are kept

    logic [PHT_INDEX_BITS-1:0]   req_pht_index;
    logic [PHT_INDEX_BITS-1:0]   fb_pht_index;
    logic [TAG_BITS-1:0]         req_tag;
    logic [TAG_BITS-1:0]         fb_tag;
    logic [CACHE_INDEX_BITS-1:0] req_cache_index;
    logic [CACHE_INDEX_BITS-1:0] fb_cache_index;

    ctr_t     req_choice_ctr;
    ctr_t     fb_choice_ctr;
    logic     req_hit;
    logic     fb_hit;
    outcome_e req_cache_dir;
    outcome_e fb_cache_dir;
    logic     req_dir;
    logic     fb_taken;
    logic     fb_choice_ok;
    logic     fb_cache_ok;
    logic     choice_upd_en;
    logic     cache_upd_en;

    // Same hashing on both sides
    assign req_pht_index   = i_req_pc[PC_ALIGN_BITS +: PHT_INDEX_BITS];
    assign fb_pht_index    = i_fb_pc[PC_ALIGN_BITS +: PHT_INDEX_BITS];
    assign req_tag         = i_req_pc[PC_ALIGN_BITS +: TAG_BITS];
    assign fb_tag          = i_fb_pc[PC_ALIGN_BITS +: TAG_BITS];
    assign req_cache_index = i_req_pc[CIDX_LSB +: CACHE_INDEX_BITS] ^ ghr;
    assign fb_cache_index  = i_fb_pc[CIDX_LSB +: CACHE_INDEX_BITS] ^ ghr;

    // Cache holds the exceptions, so it wins on a hit
    assign req_dir          = req_hit ? (req_cache_dir == TAKEN) : req_choice_ctr[CTR_BITS-1];
    assign o_req_prediction = (i_req_valid && req_dir) ? TAKEN : NOT_TAKEN;

    assign fb_taken     = (i_fb_outcome == TAKEN);
    assign fb_choice_ok = (fb_choice_ctr[CTR_BITS-1] == fb_taken);
    assign fb_cache_ok  = (fb_cache_dir == i_fb_outcome);

    // Leave the choice counter alone when the cache covered its mistake
    assign choice_upd_en = i_fb_valid && !(fb_hit && fb_cache_ok && !fb_choice_ok);
    // Train on hit, allocate on a choice miss
    assign cache_upd_en  = i_fb_valid && (fb_hit || !fb_choice_ok);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr <= '0;
        end else if (i_fb_valid) begin
            ghr <= {ghr[CACHE_INDEX_BITS-2:0], fb_taken};  // Newest outcome in bit 0
        end
    end

    choice_pht #(
        .PHT_INDEX_BITS(PHT_INDEX_BITS)
    ) u_choice_pht (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_rd_index   (req_pht_index),
        .o_rd_ctr     (req_choice_ctr),
        .i_upd_en     (choice_upd_en),
        .i_upd_index  (fb_pht_index),
        .i_upd_outcome(i_fb_outcome),
        .o_upd_ctr    (fb_choice_ctr)
    );

    direction_cache #(
        .CACHE_INDEX_BITS(CACHE_INDEX_BITS),
        .TAG_BITS        (TAG_BITS)
    ) u_direction_cache (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_rd_index   (req_cache_index),
        .i_rd_tag     (req_tag),
        .o_rd_hit     (req_hit),
        .o_rd_dir     (req_cache_dir),
        .i_upd_en     (cache_upd_en),
        .i_upd_index  (fb_cache_index),
        .i_upd_tag    (fb_tag),
        .i_upd_outcome(i_fb_outcome),
        .o_upd_hit    (fb_hit),
        .o_upd_dir    (fb_cache_dir)
    );

endmodule

// File: logic/direction_cache.sv
`timescale 1ns/1ps

module direction_cache #(
    parameter int CACHE_INDEX_BITS = 4,
    parameter int TAG_BITS         = 6
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [CACHE_INDEX_BITS-1:0] i_rd_index,
    input  logic [TAG_BITS-1:0]         i_rd_tag,
    output logic                        o_rd_hit,
    output bp_types_pkg::outcome_e      o_rd_dir,
    input  logic                        i_upd_en,
    input  logic [CACHE_INDEX_BITS-1:0] i_upd_index,
    input  logic [TAG_BITS-1:0]         i_upd_tag,
    input  bp_types_pkg::outcome_e      i_upd_outcome,
    output logic                        o_upd_hit,
    output bp_types_pkg::outcome_e      o_upd_dir
);
    import bp_types_pkg::*;
    import bp_counter_pkg::*;

    localparam int CACHE_DEPTH = 2 ** CACHE_INDEX_BITS;

    // Single-way entries, split into three arrays
    logic                entry_valid [CACHE_DEPTH];
    logic [TAG_BITS-1:0] entry_tag   [CACHE_DEPTH];
    ctr_t                entry_ctr   [CACHE_DEPTH];

    ctr_t rd_ctr;
    ctr_t upd_ctr;
    ctr_t alloc_ctr;

    // Lookup port, used by the request side
    assign rd_ctr   = entry_ctr[i_rd_index];
    assign o_rd_hit = entry_valid[i_rd_index] && (entry_tag[i_rd_index] == i_rd_tag);
    assign o_rd_dir = rd_ctr[CTR_BITS-1] ? TAKEN : NOT_TAKEN;

    // Same lookup at the feedback slot
    assign upd_ctr   = entry_ctr[i_upd_index];
    assign o_upd_hit = entry_valid[i_upd_index] && (entry_tag[i_upd_index] == i_upd_tag);
    assign o_upd_dir = upd_ctr[CTR_BITS-1] ? TAKEN : NOT_TAKEN;

    // New entry starts weak in the resolved direction
    assign alloc_ctr = (i_upd_outcome == TAKEN) ? CTR_WEAK_T : CTR_WEAK_NT;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CACHE_DEPTH; i++) begin
                entry_valid[i] <= 1'b0;  // A zero tag must not hit after reset
                entry_ctr[i]   <= CTR_WEAK_NT;
            end
        end else if (i_upd_en) begin
            if (o_upd_hit) begin
                entry_ctr[i_upd_index] <= ctr_step(upd_ctr, i_upd_outcome == TAKEN);
            end else begin
                // Replace whatever lived here
                entry_valid[i_upd_index] <= 1'b1;
                entry_ctr[i_upd_index]   <= alloc_ctr;
            end
        end
    end

    // Tag written only on allocation
    always_ff @(posedge clk) begin
        if (i_upd_en && !o_upd_hit) begin
            entry_tag[i_upd_index] <= i_upd_tag;
        end
    end

endmodule

// File: logic/choice_pht.sv
`timescale 1ns/1ps

module choice_pht #(
    parameter int PHT_INDEX_BITS = 6
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [PHT_INDEX_BITS-1:0] i_rd_index,
    output bp_counter_pkg::ctr_t      o_rd_ctr,
    input  logic                      i_upd_en,
    input  logic [PHT_INDEX_BITS-1:0] i_upd_index,
    input  bp_types_pkg::outcome_e    i_upd_outcome,
    output bp_counter_pkg::ctr_t      o_upd_ctr
);
    import bp_types_pkg::*;
    import bp_counter_pkg::*;

    localparam int PHT_DEPTH = 2 ** PHT_INDEX_BITS;

    ctr_t ctr_mem [PHT_DEPTH];  // One choice counter per PC slot

    // Both ports read combinationally
    assign o_rd_ctr  = ctr_mem[i_rd_index];
    assign o_upd_ctr = ctr_mem[i_upd_index];  // Current value at the update slot

    // Whole table starts weakly not-taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                ctr_mem[i] <= CTR_WEAK_NT;
            end
        end else if (i_upd_en) begin
            ctr_mem[i_upd_index] <= ctr_step(o_upd_ctr, i_upd_outcome == TAKEN);
        end
    end

endmodule

// File: logic/bp_counter_pkg.sv
package bp_counter_pkg;

    parameter int CTR_BITS = 2;

    // Saturating counter, MSB is the predicted direction
    typedef logic [CTR_BITS-1:0] ctr_t;

    parameter ctr_t CTR_WEAK_NT = 2'b01;  // Reset and not-taken allocation
    parameter ctr_t CTR_WEAK_T  = 2'b10;  // Taken allocation

    localparam ctr_t CTR_MIN = '0;
    localparam ctr_t CTR_MAX = '1;

    // One step toward the outcome, held at either end
    function automatic ctr_t ctr_step(input ctr_t ctr, input logic taken);
        ctr_t next;
        next = ctr;
        if (taken) begin
            if (ctr != CTR_MAX) begin
                next = ctr + ctr_t'(1);
            end
        end else begin
            if (ctr != CTR_MIN) begin
                next = ctr - ctr_t'(1);
            end
        end
        return next;
    endfunction

endpackage

// File: logic/bp_types_pkg.sv
package bp_types_pkg;

    // Instruction address width
    parameter int ADDR_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;  // PC or branch target

    // Resolved or predicted branch direction
    typedef enum logic {
        NOT_TAKEN = 1'b0,
        TAKEN     = 1'b1
    } outcome_e;

    // Branch to fall-through, skipping the delay slot
    parameter addr_t DELAY_SLOT_OFFSET = ADDR_WIDTH'(8);

    // Word aligned instructions, low bits always zero
    parameter int PC_ALIGN_BITS = 2;

endpackage
